//--- Bender.yml
package:
  name: lsu

sources:
  - verilog/lsu_pkg.sv
  - verilog/lsu_dtcm.sv
  - verilog/lsu_issue.sv
  - verilog/lsu_load_align.sv
  - verilog/lsu_top.sv
  - target: test
    files:
      - tb/lsu_chk.sv
      - tb/tb_lsu.sv

//--- filelist.f
verilog/lsu_pkg.sv
verilog/lsu_dtcm.sv
verilog/lsu_issue.sv
verilog/lsu_load_align.sv
verilog/lsu_top.sv
tb/lsu_chk.sv
tb/tb_lsu.sv

//--- tb/lsu_chk.sv
// LSU assertion checker: arbitration, reset and writeback timing rules, with its bind

`timescale 1ns/10ps

module lsu_chk (
	input logic CLK,
	input logic rst_n,
	input logic lu_valid,
	input logic su_ready,
	input logic wb_valid
);

	// Number of failed assertions
	int fail_cnt = 0;

	// Load holds off any store in its cycle
	a_load_blocks_store: assert property (@(posedge CLK) lu_valid |-> !su_ready)
		else begin
			$error("su_ready high while lu_valid is high");
			fail_cnt++;
		end

	// Quiet writeback port in reset
	a_no_wb_in_reset: assert property (@(posedge CLK) !rst_n |-> !wb_valid)
		else begin
			$error("wb_valid high during reset");
			fail_cnt++;
		end

	// Two-cycle load latency
	a_wb_follows_load: assert property (
		@(posedge CLK) disable iff (!rst_n) $rose(wb_valid) |-> $past(lu_valid, 2)
	) else begin
		$error("wb_valid rose without a load two cycles before");
		fail_cnt++;
	end

endmodule

// Every LSU top gets a checker
bind lsu_top lsu_chk i_lsu_chk (
	.CLK      (CLK),
	.rst_n    (rst_n),
	.lu_valid (lu_valid),
	.su_ready (su_ready),
	.wb_valid (wb_valid)
);

//--- tb/tb_lsu.sv
// LSU testbench: clock, reset, byte-array reference model, directed and random tests, compare, summary

`timescale 1ns/10ps

module tb_lsu;

	import lsu_pkg::*;

	localparam int AW = 6;
	// Bytes covered by both banks
	localparam int MEM_BYTES = 16 * (2 ** AW);

	// Expected writeback and the edge count it must show up at
	typedef struct packed {
		data_t       data;
		rd_tag_t     tag;
		logic [31:0] cyc;
	} exp_t;

	logic       CLK = 1'b0;
	logic       rst_n;
	logic       lu_valid;
	load_req_t  lu_req;
	logic       su_valid;
	store_req_t su_req;
	logic       flush;
	logic       su_ready;
	logic       wb_valid;
	data_t      wb_data;
	rd_tag_t    wb_tag;

	// Reference memory and loads in flight
	logic [7:0]  mem_model [MEM_BYTES];
	exp_t        exp_q [$];
	logic [31:0] cyc = '0;
	rd_tag_t     tag_cnt = '0;
	int          errors = 0;
	int          n_checks = 0;
	int          n_tests = 0;

	lsu_top #(
		.AW(AW)
	) i_lsu_top (
		.CLK      (CLK),
		.rst_n    (rst_n),
		.lu_valid (lu_valid),
		.lu_req   (lu_req),
		.su_valid (su_valid),
		.su_req   (su_req),
		.flush    (flush),
		.su_ready (su_ready),
		.wb_valid (wb_valid),
		.wb_data  (wb_data),
		.wb_tag   (wb_tag)
	);

	// 20 ns clock
	always #10 CLK = ~CLK;

	// Rising edge count
	always @(posedge CLK) cyc <= cyc + 1;

	// Loaded bytes in address order, wrapping at the top, then extended
	function automatic data_t ref_load(data_t addr, access_size_t sz, logic uns);
		data_t v;
		int    n;
		v = '0;
		n = 1 << sz;
		for (int i = 0; i < n; i++) begin
			v[8*i +: 8] = mem_model[(addr + i) % MEM_BYTES];
		end
		if (!uns && n < 8 && v[8*n-1]) begin
			for (int i = 8 * n; i < 64; i++) begin
				v[i] = 1'b1;
			end
		end
		return v;
	endfunction

	function automatic void model_store(store_req_t sr);
		for (int i = 0; i < (1 << sr.size); i++) begin
			mem_model[(sr.addr + i) % MEM_BYTES] = sr.data[8*i +: 8];
		end
	endfunction

	// Fresh tag per load
	function automatic load_req_t next_load(data_t addr, access_size_t sz, logic uns);
		load_req_t lr;
		lr = '{size: sz, is_unsigned: uns, tag: tag_cnt, addr: addr};
		tag_cnt = tag_cnt + 1;
		return lr;
	endfunction

	task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
		n_checks++;
		if (got !== exp) begin
			errors++;
			$display("error %s: got %h expected %h", name, got, exp);
		end
	endtask

	// One cycle of stimulus; kill marks a load that a flush will drop
	task automatic step(input logic ld, input load_req_t lr, input logic st,
			input store_req_t sr, input logic fl, input logic kill);
		exp_t e;
		@(posedge CLK);
		lu_valid <= ld;
		lu_req   <= lr;
		su_valid <= st;
		su_req   <= sr;
		flush    <= fl;
		// Accepted in the coming cycle, writeback two cycles on
		if (ld && !kill) begin
			e.data = ref_load(lr.addr, lr.size, lr.is_unsigned);
			e.tag  = lr.tag;
			e.cyc  = cyc + 3;
			exp_q.push_back(e);
		end
		// Store only taken without a load
		if (st && !ld) begin
			model_store(sr);
		end
	endtask

	task automatic do_load(input data_t addr, input access_size_t sz, input logic uns);
		step(1'b1, next_load(addr, sz, uns), 1'b0, '0, 1'b0, 1'b0);
	endtask

	task automatic do_store(input data_t addr, input access_size_t sz, input data_t data);
		step(1'b0, '0, 1'b1, '{size: sz, addr: addr, data: data}, 1'b0, 1'b0);
	endtask

	// Idle the inputs and wait for every load to come back
	task automatic end_test(input string name, input int err0);
		int n;
		n = 0;
		@(posedge CLK);
		lu_valid <= 1'b0;
		su_valid <= 1'b0;
		flush    <= 1'b0;
		while (exp_q.size() != 0 && n < 20) begin
			@(negedge CLK);
			n++;
		end
		if (exp_q.size() != 0) begin
			$display("timeout: %0d loads never wrote back", exp_q.size());
			errors++;
			exp_q.delete();
		end
		n_tests++;
		$display("test %0d %s: %0d errors", n_tests, name, errors - err0);
	endtask

	// Writeback compare at the falling edge
	always @(negedge CLK) begin : compare
		exp_t e;
		if (rst_n) begin
			if (wb_valid) begin
				if (exp_q.size() == 0) begin
					$display("writeback with tag %h but no load was in flight", wb_tag);
					errors++;
				end else begin
					e = exp_q.pop_front();
					check("wb_cycle", cyc, e.cyc);
					check("wb_data", wb_data, e.data);
					check("wb_tag", wb_tag, e.tag);
				end
			end else if (exp_q.size() != 0 && exp_q[0].cyc <= cyc) begin
				e = exp_q.pop_front();
				$display("load with tag %h gave no writeback in time", e.tag);
				errors++;
			end
		end
	end

	initial begin : main
		int unsigned r;
		int          err0;
		int          ops;
		int          guard;
		data_t       a;
		data_t       d;
		logic        pend;
		store_req_t  sr;

		void'($urandom(32'h033aa601));
		rst_n    = 1'b1;
		lu_valid = 1'b0;
		lu_req   = '0;
		su_valid = 1'b0;
		su_req   = '0;
		flush    = 1'b0;
		// Reset edge after time zero so the async reset fires
		#2 rst_n = 1'b0;

		// Reset, then fill memory
		err0 = errors;
		for (int i = 0; i < 10; i++) begin
			@(posedge CLK);
			lu_valid <= (i < 8) ? i[0] : 1'b0;
			@(negedge CLK);
			check("wb_valid", wb_valid, 0);
			check("su_ready", su_ready, !lu_valid);
		end
		@(posedge CLK);
		rst_n <= 1'b1;
		for (int i = 0; i < MEM_BYTES / 8; i++) begin
			do_store(i * 8, SIZE_D, {$urandom, $urandom});
		end
		end_test("reset and fill", err0);

		// Aligned stores of each size, loads of every size and sign
		err0 = errors;
		for (int s = 0; s < 4; s++) begin
			a = 64 + s * 16 + (s % 2) * 8;
			d = {$urandom, $urandom};
			if (s[0]) begin
				d = d | 64'h8000_0000_8000_8080;
			end
			do_store(a, access_size_t'(s), d);
			for (int l = 0; l < 8; l++) begin
				do_load(a, access_size_t'(l / 2), l[0]);
			end
		end
		end_test("aligned sizes", err0);

		// Offsets 1 to 7 in both banks
		err0 = errors;
		for (int off = 1; off < 8; off++) begin
			a = 256 + off * 16 + (off % 2) * 8 + off;
			for (int s = 1; s < 4; s++) begin
				do_store(a, access_size_t'(s), {$urandom, $urandom});
				for (int l = 2; l < 8; l++) begin
					do_load(a, access_size_t'(l / 2), l[0]);
				end
			end
		end
		// Last double-word wraps to the first
		do_store(MEM_BYTES - 3, SIZE_D, {$urandom, $urandom});
		do_load(MEM_BYTES - 3, SIZE_D, 1'b0);
		end_test("misaligned", err0);

		// Load beats a held store
		err0 = errors;
		a  = 512 + 5;
		d  = ~ref_load(a, SIZE_D, 1'b1);
		sr = '{size: SIZE_D, addr: a, data: d};
		for (int i = 0; i < 2; i++) begin
			step(1'b1, next_load(a, SIZE_D, 1'b1), 1'b1, sr, 1'b0, 1'b0);
			@(negedge CLK);
			check("su_ready", su_ready, 0);
		end
		step(1'b0, '0, 1'b1, sr, 1'b0, 1'b0);
		@(negedge CLK);
		check("su_ready", su_ready, 1);
		do_load(a, SIZE_D, 1'b1);
		end_test("priority", err0);

		// Flush in cycles 2 and 7 drops those loads and the ones just before
		err0 = errors;
		for (int k = 0; k < 10; k++) begin
			step(1'b1, next_load({$urandom, $urandom}, access_size_t'(k % 4), k[0]), 1'b0, '0,
				k == 2 || k == 7, k == 1 || k == 2 || k == 6 || k == 7);
		end
		end_test("flush", err0);

		// Random mix, a refused store stays until taken
		err0  = errors;
		pend  = 1'b0;
		ops   = 0;
		guard = 0;
		while (ops < 300 && guard < 2000) begin
			r = $urandom;
			if (!pend && r[1]) begin
				sr = '{size: r[5:4], addr: {$urandom, $urandom}, data: {$urandom, $urandom}};
				pend = 1'b1;
			end
			step(r[0], next_load({$urandom, $urandom}, r[3:2], r[6]), pend, sr, 1'b0, 1'b0);
			ops = ops + int'(r[0]) + int'(pend && !r[0]);
			if (pend && !r[0]) begin
				pend = 1'b0;
			end
			guard++;
		end
		if (ops < 300) begin
			$display("random mix stopped after %0d of 300 operations", ops);
			errors++;
		end
		end_test("random mix", err0);

		// Failures flagged by the bound checker
		errors += i_lsu_top.i_lsu_chk.fail_cnt;

		$display("summary: %0d tests, %0d checks, %0d errors", n_tests, n_checks, errors);
		if (errors == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

//--- verilog/lsu_dtcm.sv
// One data memory bank: 64-bit words, byte-masked write, registered read

`timescale 1ns/10ps

module lsu_dtcm #(
	parameter int AW = 14
) (
	input  logic              CLK,
	input  logic [AW-1:0]     addr,
	input  lsu_pkg::bank_wr_t wr,
	output lsu_pkg::data_t    rdata
);

	import lsu_pkg::*;

	// Words per bank and bytes per word
	localparam int DEPTH = 2 ** AW;
	localparam int NBYTE = $bits(byte_mask_t);

	// Storage array
	data_t mem [DEPTH];

	// Byte lanes written only where the mask is set
	always_ff @(posedge CLK) begin
		if (wr.wen) begin
			for (int i = 0; i < NBYTE; i++) begin
				if (wr.wmask[i]) begin
					mem[addr][i*8 +: 8] <= wr.wdata[i*8 +: 8];
				end
			end
		end
	end

	// Read word registered at every edge
	// Old contents returned when the same word is written in that cycle
	always_ff @(posedge CLK) begin
		rdata <= mem[addr];
	end

endmodule

//--- verilog/lsu_issue.sv
// LSU issue stage: load/store arbitration, bank address split, store masks and data, load context

`timescale 1ns/10ps

module lsu_issue #(
	parameter int AW = 14
) (
	input  logic                 CLK,
	input  logic                 rst_n,
	input  logic                 lu_valid,
	input  lsu_pkg::load_req_t   lu_req,
	input  logic                 su_valid,
	input  lsu_pkg::store_req_t  su_req,
	input  logic                 flush,
	output logic                 su_ready,
	output logic [AW-1:0]        addr_a,
	output logic [AW-1:0]        addr_b,
	output lsu_pkg::bank_wr_t    wr_a,
	output lsu_pkg::bank_wr_t    wr_b,
	output lsu_pkg::load_ctx_t   ctx
);

	import lsu_pkg::*;

	// Arbitration results
	logic          store_fire;
	data_t         sel_addr;

	// Bank pair of the chosen address
	logic [AW-1:0] pair_idx;
	logic          odd_dw;

	// Store window over two double-words
	logic [15:0]   mask_win;
	logic [127:0]  data_win;
	logic [2:0]    byte_off;

	// Load context registers
	logic          ctx_valid_q;
	access_size_t  size_q;
	logic          unsigned_q;
	rd_tag_t       tag_q;
	logic [3:0]    offset_q;

	// Load wins, a store waits while a load is present
	assign su_ready   = ~lu_valid;
	assign store_fire = su_valid & su_ready;

	// One address feeds both banks
	assign sel_addr = lu_valid ? lu_req.addr : su_req.addr;
	assign odd_dw   = sel_addr[3];
	assign pair_idx = sel_addr[4 +: AW];

	// Even double-word lives in bank A, odd in bank B
	// Odd start means bank A supplies the next pair
	assign addr_a = odd_dw ? pair_idx + 1'b1 : pair_idx;
	assign addr_b = pair_idx;

	assign byte_off = su_req.addr[2:0];

	// Byte mask of the store size, moved to the byte offset
	always_comb begin
		unique case (su_req.size)
			SIZE_B:  mask_win = 16'h0001 << byte_off;
			SIZE_H:  mask_win = 16'h0003 << byte_off;
			SIZE_W:  mask_win = 16'h000f << byte_off;
			default: mask_win = 16'h00ff << byte_off;
		endcase
	end

	// Store data moved by the same offset in bits
	assign data_win = {64'b0, su_req.data} << {byte_off, 3'b000};

	// Low half of the window goes to the bank holding the addressed double-word
	always_comb begin
		if (odd_dw) begin
			wr_b.wmask = mask_win[7:0];
			wr_a.wmask = mask_win[15:8];
			wr_b.wdata = data_win[63:0];
			wr_a.wdata = data_win[127:64];
		end else begin
			wr_a.wmask = mask_win[7:0];
			wr_b.wmask = mask_win[15:8];
			wr_a.wdata = data_win[63:0];
			wr_b.wdata = data_win[127:64];
		end
		// Bank untouched by the window skips the write
		wr_a.wen = store_fire & (|wr_a.wmask);
		wr_b.wen = store_fire & (|wr_b.wmask);
	end

	// Valid bit of the load in flight, flush drops it here
	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			ctx_valid_q <= 1'b0;
		end else begin
			ctx_valid_q <= lu_valid & ~flush;
		end
	end

	// Load attributes follow the bank read by one cycle
	always_ff @(posedge CLK) begin
		if (lu_valid) begin
			size_q     <= lu_req.size;
			unsigned_q <= lu_req.is_unsigned;
			tag_q      <= lu_req.tag;
			offset_q   <= lu_req.addr[3:0];
		end
	end

	always_comb begin
		ctx.size        = size_q;
		ctx.is_unsigned = unsigned_q;
		ctx.tag         = tag_q;
		ctx.offset      = offset_q;
		ctx.valid       = ctx_valid_q;
	end

endmodule

//--- verilog/lsu_load_align.sv
// LSU align stage: bank word merge, byte extraction, sign/zero extension, writeback register

`timescale 1ns/10ps

module lsu_load_align #(
	parameter int AW = 14
) (
	input  logic               CLK,
	input  logic               rst_n,
	input  lsu_pkg::load_ctx_t ctx,
	input  lsu_pkg::data_t     rdata_a,
	input  lsu_pkg::data_t     rdata_b,
	input  logic               flush,
	output logic               wb_valid,
	output lsu_pkg::data_t     wb_data,
	output lsu_pkg::rd_tag_t   wb_tag
);

	import lsu_pkg::*;

	// Two double-words in address order
	logic [127:0] window;
	logic [127:0] shifted;
	data_t        raw;
	data_t        ext;

	// Bank holding the addressed double-word goes low
	assign window = ctx.offset[3] ? {rdata_a, rdata_b} : {rdata_b, rdata_a};

	// First loaded byte moved to bit 0
	assign shifted = window >> {ctx.offset[2:0], 3'b000};
	assign raw     = shifted[63:0];

	// Width and extension per load type
	always_comb begin
		unique case (ctx.size)
			SIZE_B: begin
				ext = ctx.is_unsigned ? {56'b0, raw[7:0]} : {{56{raw[7]}}, raw[7:0]};
			end
			SIZE_H: begin
				ext = ctx.is_unsigned ? {48'b0, raw[15:0]} : {{48{raw[15]}}, raw[15:0]};
			end
			SIZE_W: begin
				ext = ctx.is_unsigned ? {32'b0, raw[31:0]} : {{32{raw[31]}}, raw[31:0]};
			end
			default: begin
				ext = raw;
			end
		endcase
	end

	// Writeback strobe, flush in the second cycle still kills it
	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			wb_valid <= 1'b0;
		end else begin
			wb_valid <= ctx.valid & ~flush;
		end
	end

	// Result and tag held until the next load arrives
	always_ff @(posedge CLK) begin
		if (ctx.valid) begin
			wb_data <= ext;
			wb_tag  <= ctx.tag;
		end
	end

endmodule

//--- verilog/lsu_pkg.sv
// Shared LSU types: data, mask, size and tag vectors, request, bank write and load context structs

package lsu_pkg;

	// 64-bit data word, also used for byte addresses
	typedef logic [63:0] data_t;

	// One write enable per byte of a bank word
	typedef logic [7:0] byte_mask_t;

	// Access width, log2 of the byte count
	typedef logic [1:0] access_size_t;

	localparam access_size_t SIZE_B = 2'd0;
	localparam access_size_t SIZE_H = 2'd1;
	localparam access_size_t SIZE_W = 2'd2;
	localparam access_size_t SIZE_D = 2'd3;

	// Destination register tag
	localparam int TAG_W = 8;
	typedef logic [TAG_W-1:0] rd_tag_t;

	// Load request, 75 bits
	typedef struct packed {
		access_size_t size;
		logic         is_unsigned;
		rd_tag_t      tag;
		data_t        addr;
	} load_req_t;

	// Store request, 130 bits
	typedef struct packed {
		access_size_t size;
		data_t        addr;
		data_t        data;
	} store_req_t;

	// Write port of one bank, 73 bits
	typedef struct packed {
		logic       wen;
		byte_mask_t wmask;
		data_t      wdata;
	} bank_wr_t;

	// Load in flight between issue and align
	typedef struct packed {
		access_size_t size;
		logic         is_unsigned;
		rd_tag_t      tag;
		logic [3:0]   offset;
		logic         valid;
	} load_ctx_t;

endpackage

//--- verilog/lsu_top.sv
// LSU top: issue stage, two data memory banks and align stage

`timescale 1ns/10ps

module lsu_top #(
	parameter int AW = 14
) (
	input  logic                CLK,
	input  logic                rst_n,
	input  logic                lu_valid,
	input  lsu_pkg::load_req_t  lu_req,
	input  logic                su_valid,
	input  lsu_pkg::store_req_t su_req,
	input  logic                flush,
	output logic                su_ready,
	output logic                wb_valid,
	output lsu_pkg::data_t      wb_data,
	output lsu_pkg::rd_tag_t    wb_tag
);

	import lsu_pkg::*;

	// Bank indices
	logic [AW-1:0] addr_a;
	logic [AW-1:0] addr_b;

	// Bank write ports
	bank_wr_t      wr_a;
	bank_wr_t      wr_b;

	// Registered read words
	data_t         rdata_a;
	data_t         rdata_b;

	// Load context, issue to align
	load_ctx_t     ctx;

	// Arbitration and address split
	lsu_issue #(
		.AW(AW)
	) i_issue (
		.CLK      (CLK),
		.rst_n    (rst_n),
		.lu_valid (lu_valid),
		.lu_req   (lu_req),
		.su_valid (su_valid),
		.su_req   (su_req),
		.flush    (flush),
		.su_ready (su_ready),
		.addr_a   (addr_a),
		.addr_b   (addr_b),
		.wr_a     (wr_a),
		.wr_b     (wr_b),
		.ctx      (ctx)
	);

	// Even double-words
	lsu_dtcm #(
		.AW(AW)
	) i_dtcm_a (
		.CLK   (CLK),
		.addr  (addr_a),
		.wr    (wr_a),
		.rdata (rdata_a)
	);

	// Odd double-words
	lsu_dtcm #(
		.AW(AW)
	) i_dtcm_b (
		.CLK   (CLK),
		.addr  (addr_b),
		.wr    (wr_b),
		.rdata (rdata_b)
	);

	// Extraction and writeback
	lsu_load_align #(
		.AW(AW)
	) i_load_align (
		.CLK      (CLK),
		.rst_n    (rst_n),
		.ctx      (ctx),
		.rdata_a  (rdata_a),
		.rdata_b  (rdata_b),
		.flush    (flush),
		.wb_valid (wb_valid),
		.wb_data  (wb_data),
		.wb_tag   (wb_tag)
	);

endmodule
